/* rtl/zx_pkg.sv */
package zx_pkg;

	//////////////////////
	// memory windows
	//////////////////////
	localparam int win_count = 4;
	localparam int page_w = 8;
	localparam int rompg_w = 5;

	// low address bytes of the decoded ports
	localparam logic [7:0] port_7ffd_lo = 8'hFD;
	localparam logic [7:0] port_eff7_lo = 8'hF7;
	localparam logic [7:0] port_f7_lo = 8'hF7;

	// high address bytes for dos entry and exit
	localparam logic [7:0] dos_entry_hi = 8'h3D;
	localparam logic [7:0] ram_low_hi = 8'h40;

	// fclk cycles per z80 clock
	localparam int div_slow = 8;
	localparam int div_fast = 4;

	// frame length, short for simulation
	localparam int frame_fclks = 1024;
	localparam int int_len = 32;

	// xxF7 data word, seen as a ram page
	typedef struct packed {
		logic romnram;
		logic [6:0] page;
	} ram_view_t;

	// same word seen as a rom page
	typedef struct packed {
		logic romnram;
		logic [6-rompg_w:0] spare;
		logic [rompg_w-1:0] page;
	} rom_view_t;

	typedef union packed {
		ram_view_t ram;
		rom_view_t rom;
	} pager_word_u;

endpackage

/* rtl/z_clock.sv */
`timescale 1ns/1ns

module z_clock (
	input  logic fclk,
	input  logic rst_n,
	input  logic turbo,
	output logic clkz_out,
	output logic zpos,
	output logic zneg
);
	import zx_pkg::*;

	localparam int cnt_w = $clog2(div_slow);

	logic [cnt_w-1:0] cnt;
	logic slow;
	logic [cnt_w-1:0] last;
	logic [cnt_w-1:0] half_end;

	// period follows the mode latched at the last boundary
	assign last = slow ? cnt_w'(div_slow - 1) : cnt_w'(div_fast - 1);
	assign half_end = slow ? cnt_w'(div_slow / 2 - 1) : cnt_w'(div_fast / 2 - 1);

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			cnt <= '0;
			slow <= 1'b0;
			clkz_out <= 1'b0;
			zpos <= 1'b0;
			zneg <= 1'b0;
		end
		else
		begin
			zpos <= 1'b0;
			zneg <= 1'b0;
			if (cnt == last)
			begin
				// new period starts high, mode may switch here
				cnt <= '0;
				slow <= ~turbo;
				clkz_out <= 1'b1;
				zpos <= 1'b1;
			end
			else
			begin
				cnt <= cnt + 1'b1;
				if (cnt == half_end)
				begin
					clkz_out <= 1'b0;
					zneg <= 1'b1;
				end
			end
		end
	end

	a_edges_apart: assert property (@(posedge fclk) disable iff (!rst_n)
		!(zpos && zneg));

endmodule

/* rtl/z_ports.sv */
`timescale 1ns/1ns

module z_ports (
	input  logic fclk,
	input  logic rst_n,
	input  logic zpos,
	input  logic [15:0] a,
	input  logic [7:0] d,
	input  logic iorq_n,
	input  logic wr_n,
	output logic [7:0] p7ffd,
	output logic [7:0] peff7,
	output logic f7_wr,
	output logic [1:0] f7_win,
	output logic f7_bank,
	output zx_pkg::pager_word_u f7_data
);
	import zx_pkg::*;

	logic taken;
	logic io_wr;
	logic hit_7ffd;
	logic hit_eff7;
	logic hit_f7;

	//////////////////////
	// address decode
	//////////////////////
	assign hit_7ffd = (a[7:0] == port_7ffd_lo) && (a[15:12] == 4'h7);
	assign hit_eff7 = (a[7:0] == port_eff7_lo) && (a[15:12] == 4'hE);
	assign hit_f7 = (a[7:0] == port_f7_lo) && (a[15:12] != 4'hE);

	// first zpos of an io write cycle only
	assign io_wr = zpos && !iorq_n && !wr_n && !taken;

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			taken <= 1'b0;
			p7ffd <= 8'h00;
			peff7 <= 8'h00;
		end
		else
		begin
			if (iorq_n)
				taken <= 1'b0;
			else if (io_wr)
				taken <= 1'b1;
			if (io_wr && hit_7ffd)
				p7ffd <= d;
			if (io_wr && hit_eff7)
				peff7 <= d;
		end
	end

	// window write goes straight to the pagers
	assign f7_wr = io_wr && hit_f7;
	assign f7_win = a[15:14];
	assign f7_bank = a[11];
	assign f7_data = d;

	a_one_write: assert property (@(posedge fclk) disable iff (!rst_n)
		io_wr |=> (!io_wr until iorq_n));

endmodule

/* rtl/atm_pager.sv */
`timescale 1ns/1ns

module atm_pager #(
	parameter int win_index = 0
) (
	input  logic fclk,
	input  logic rst_n,
	input  logic zpos,
	input  logic [15:0] a,
	input  logic mreq_n,
	input  logic m1_n,
	input  logic dos,
	input  logic [7:0] p7ffd,
	input  logic [7:0] peff7,
	input  logic f7_wr,
	input  logic [1:0] f7_win,
	input  logic f7_bank,
	input  zx_pkg::pager_word_u f7_data,
	output logic [zx_pkg::page_w-1:0] page,
	output logic romnram,
	output logic dos_on,
	output logic dos_off
);
	import zx_pkg::*;

	pager_word_u word_norm;
	pager_word_u word_dos;
	pager_word_u cur;
	logic fetch;

	// both banks come up as rom page 3
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			word_norm <= 8'h83;
			word_dos <= 8'h83;
		end
		else if (f7_wr && (f7_win == 2'(win_index)))
		begin
			if (f7_bank)
				word_dos <= f7_data;
			else
				word_norm <= f7_data;
		end
	end

	assign cur = dos ? word_dos : word_norm;

	//////////////////////
	// page selection
	//////////////////////
	always_comb
	begin
		if (peff7[2])
		begin
			romnram = cur.rom.romnram;
			if (cur.rom.romnram)
				page = {{(page_w - rompg_w){1'b0}}, cur.rom.page};
			else
				page = {1'b0, cur.ram.page};
		end
		else
		begin
			// pentagon layout
			case (win_index)
				0:
				begin
					romnram = 1'b1;
					page = {{(page_w - 2){1'b0}}, ~dos, p7ffd[4]};
				end
				1:
				begin
					romnram = 1'b0;
					page = page_w'(5);
				end
				2:
				begin
					romnram = 1'b0;
					page = page_w'(2);
				end
				default:
				begin
					romnram = 1'b0;
					page = {{(page_w - 3){1'b0}}, p7ffd[2:0]};
				end
			endcase
		end
	end

	// opcode fetch inside this window
	assign fetch = zpos && !mreq_n && !m1_n && (a[15:14] == 2'(win_index));
	assign dos_on = fetch && (a[15:8] == dos_entry_hi) && romnram && !dos;
	assign dos_off = fetch && (a[15:8] >= ram_low_hi) && !romnram;

endmodule

/* rtl/z_dos.sv */
`timescale 1ns/1ns

module z_dos (
	input  logic fclk,
	input  logic rst_n,
	input  logic [zx_pkg::win_count-1:0] dos_on,
	input  logic [zx_pkg::win_count-1:0] dos_off,
	output logic dos
);

	// any window may request entry or exit
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			dos <= 1'b0;
		else if (|dos_on)
			dos <= 1'b1;
		else if (|dos_off)
			dos <= 1'b0;
	end

	// requests come from different pagers
	a_on_off_apart: assert property (@(posedge fclk) disable iff (!rst_n)
		!((|dos_on) && (|dos_off)));

endmodule

/* rtl/z_mem_map.sv */
`timescale 1ns/1ns

module z_mem_map (
	input  logic [15:0] a,
	input  logic mreq_n,
	input  logic [zx_pkg::win_count-1:0][zx_pkg::page_w-1:0] pages,
	input  logic [zx_pkg::win_count-1:0] romnrams,
	output logic [zx_pkg::rompg_w-1:0] rompg,
	output logic [zx_pkg::page_w-1:0] ram_page,
	output logic romnram_cur,
	output logic csrom
);
	import zx_pkg::*;

	logic [1:0] win;
	logic [page_w-1:0] sel_page;

	//////////////////////
	// window select
	//////////////////////
	assign win = a[15:14];
	assign sel_page = pages[win];
	assign romnram_cur = romnrams[win];

	// rom page lines take the low bits
	assign rompg = sel_page[rompg_w-1:0];
	assign ram_page = sel_page;

	// rom chip select only during a memory cycle
	assign csrom = romnram_cur && !mreq_n;

endmodule

/* rtl/z_int.sv */
`timescale 1ns/1ns

module z_int (
	input  logic fclk,
	input  logic rst_n,
	input  logic iorq_n,
	input  logic m1_n,
	output logic int_n
);
	import zx_pkg::*;

	localparam int frame_w = $clog2(frame_fclks);
	localparam int len_w = $clog2(int_len);

	logic [frame_w-1:0] frame_cnt;
	logic [len_w-1:0] len_cnt;
	logic int_start;
	logic int_ack;

	assign int_start = (frame_cnt == frame_w'(frame_fclks - 1));
	assign int_ack = !iorq_n && !m1_n;

	//////////////////////
	// frame counter and pulse
	//////////////////////
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			frame_cnt <= '0;
			len_cnt <= '0;
			int_n <= 1'b1;
		end
		else
		begin
			frame_cnt <= int_start ? '0 : frame_cnt + 1'b1;
			if (int_start)
			begin
				int_n <= 1'b0;
				len_cnt <= '0;
			end
			else if (!int_n)
			begin
				len_cnt <= len_cnt + 1'b1;
				// ends on length or on cpu acknowledge
				if (int_ack || (len_cnt == len_w'(int_len - 1)))
					int_n <= 1'b1;
			end
		end
	end

	a_int_len: assert property (@(posedge fclk) disable iff (!rst_n)
		$fell(int_n) |-> ##[1:int_len] int_n);

endmodule

/* rtl/zx_core_top.sv */
`timescale 1ns/1ns

module zx_core_top (
	input  logic fclk,
	input  logic rst_n,
	input  logic [15:0] a,
	input  logic [7:0] d,
	input  logic mreq_n,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	input  logic m1_n,
	output logic clkz_out,
	output logic int_n,
	output logic csrom,
	output logic [zx_pkg::rompg_w-1:0] rompg,
	output logic [zx_pkg::page_w-1:0] ram_page,
	output logic romnram_cur
);
	import zx_pkg::*;

	logic zpos;
	logic [7:0] p7ffd;
	logic [7:0] peff7;
	logic f7_wr;
	logic [1:0] f7_win;
	logic f7_bank;
	pager_word_u f7_data;
	logic dos;
	logic [win_count-1:0] dos_on;
	logic [win_count-1:0] dos_off;
	logic [win_count-1:0][page_w-1:0] pages;
	logic [win_count-1:0] romnrams;

	// turbo is on while EFF7 bit 4 is clear
	z_clock z_clock_i (.fclk(fclk), .rst_n(rst_n), .turbo(~peff7[4]),
		.clkz_out(clkz_out), .zpos(zpos), .zneg());

	z_ports z_ports_i (.fclk(fclk), .rst_n(rst_n), .zpos(zpos), .a(a), .d(d),
		.iorq_n(iorq_n), .wr_n(wr_n), .p7ffd(p7ffd), .peff7(peff7), .f7_wr(f7_wr),
		.f7_win(f7_win), .f7_bank(f7_bank), .f7_data(f7_data));

	//////////////////////
	// one pager per window
	for (genvar i = 0; i < win_count; i++)
	begin : g_pager
		atm_pager #(.win_index(i)) atm_pager_i (.fclk(fclk), .rst_n(rst_n), .zpos(zpos),
			.a(a), .mreq_n(mreq_n), .m1_n(m1_n), .dos(dos), .p7ffd(p7ffd), .peff7(peff7),
			.f7_wr(f7_wr), .f7_win(f7_win), .f7_bank(f7_bank), .f7_data(f7_data),
			.page(pages[i]), .romnram(romnrams[i]), .dos_on(dos_on[i]),
			.dos_off(dos_off[i]));
	end

	z_dos z_dos_i (.fclk(fclk), .rst_n(rst_n), .dos_on(dos_on), .dos_off(dos_off),
		.dos(dos));

	z_mem_map z_mem_map_i (.a(a), .mreq_n(mreq_n), .pages(pages), .romnrams(romnrams),
		.rompg(rompg), .ram_page(ram_page), .romnram_cur(romnram_cur), .csrom(csrom));

	z_int z_int_i (.fclk(fclk), .rst_n(rst_n), .iorq_n(iorq_n), .m1_n(m1_n),
		.int_n(int_n));

endmodule

/* test/tb_zx_core.sv */
`timescale 1ns/1ns

module tb_zx_core;

	localparam int rec_max = 64;
	localparam int hold_fclks = 16;
	localparam int wait_limit = 4096;

	logic fclk;
	logic rst_n;
	logic [15:0] a;
	logic [7:0] d;
	logic mreq_n;
	logic iorq_n;
	logic rd_n;
	logic wr_n;
	logic m1_n;
	logic clkz_out;
	logic int_n;
	logic csrom;
	logic [zx_pkg::rompg_w-1:0] rompg;
	logic [zx_pkg::page_w-1:0] ram_page;
	logic romnram_cur;

	// op, address, data, expected value, romnram, csrom
	logic [51:0] records [0:rec_max-1];

	zx_core_top zx_core_top_i (.fclk(fclk), .rst_n(rst_n), .a(a), .d(d), .mreq_n(mreq_n),
		.iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .m1_n(m1_n), .clkz_out(clkz_out),
		.int_n(int_n), .csrom(csrom), .rompg(rompg), .ram_page(ram_page),
		.romnram_cur(romnram_cur));

	initial
	begin
		fclk = 1'b0;
		forever
			#2 fclk = ~fclk;
	end

	//////////////////////
	// reporting
	//////////////////////
	task automatic fail_run();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		if (got !== expected)
		begin
			$display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
			fail_run();
		end
	endtask

	task automatic timed_out(input string what);
		$display("timeout while waiting for %s", what);
		fail_run();
	endtask

	//////////////////////
	// bus cycles
	//////////////////////
	task automatic bus_idle();
		a = 16'h0000;
		d = 8'h00;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		m1_n = 1'b1;
	endtask

	task automatic hold_bus();
		for (int i = 0; i < hold_fclks; i++)
			@(negedge fclk);
	endtask

	task automatic check_map(input logic [15:0] addr, input logic [15:0] expected,
		input logic rn, input logic cs);
		if (rn)
			check_value(rompg, expected, $sformatf("rompg at %04h", addr));
		else
			check_value(ram_page, expected, $sformatf("ram_page at %04h", addr));
		check_value(romnram_cur, rn, $sformatf("romnram_cur at %04h", addr));
		check_value(csrom, cs, $sformatf("csrom at %04h", addr));
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge fclk);
		a = addr;
		d = data;
		iorq_n = 1'b0;
		wr_n = 1'b0;
		hold_bus();
		bus_idle();
		// iorq_n high for a cycle between writes
		@(negedge fclk);
	endtask

	task automatic m1_fetch(input logic [15:0] addr);
		@(negedge fclk);
		a = addr;
		mreq_n = 1'b0;
		rd_n = 1'b0;
		m1_n = 1'b0;
		hold_bus();
		bus_idle();
		@(negedge fclk);
	endtask

	task automatic mem_read(input logic [15:0] addr, input logic [15:0] expected,
		input logic rn, input logic cs);
		@(negedge fclk);
		a = addr;
		mreq_n = 1'b0;
		rd_n = 1'b0;
		hold_bus();
		check_map(addr, expected, rn, cs);
		bus_idle();
	endtask

	task automatic idle_check(input logic [15:0] addr, input logic [15:0] expected,
		input logic rn, input logic cs);
		@(negedge fclk);
		a = addr;
		@(negedge fclk);
		check_map(addr, expected, rn, cs);
	endtask

	//////////////////////
	// clock and interrupt timing
	//////////////////////
	task automatic measure_clkz(input logic [15:0] expected);
		int rises;
		int since;
		int guard;
		int period;
		logic prev;
		rises = 0;
		since = 0;
		guard = 0;
		period = 0;
		prev = clkz_out;
		// first full period after an edge, mode switch has settled by then
		while (rises < 3 && guard < wait_limit)
		begin
			@(negedge fclk);
			guard++;
			since++;
			if (clkz_out && !prev)
			begin
				rises++;
				if (rises == 3)
					period = since;
				since = 0;
			end
			prev = clkz_out;
		end
		if (rises < 3)
			timed_out("clkz_out rising edges");
		check_value(period, expected, "clkz_out period in fclk");
	endtask

	task automatic reset_first_int(input logic [15:0] expected, input logic level);
		int cycles;
		@(negedge fclk);
		bus_idle();
		rst_n = 1'b0;
		@(negedge fclk);
		@(negedge fclk);
		rst_n = 1'b1;
		check_value(int_n, level, "int_n after reset");
		// the last reset edge counts as the first fclk
		cycles = 1;
		while (int_n && cycles < wait_limit)
		begin
			@(negedge fclk);
			cycles++;
		end
		if (int_n)
			timed_out("the first int_n fall");
		check_value(cycles, expected, "fclk from reset to int_n fall");
	endtask

	task automatic wait_int_fall();
		int guard;
		guard = 0;
		while (int_n && guard < wait_limit)
		begin
			@(negedge fclk);
			guard++;
		end
		if (int_n)
			timed_out("int_n to fall");
	endtask

	task automatic count_int_low(input logic [15:0] expected, input string what);
		int len;
		len = 0;
		while (!int_n && len < wait_limit)
		begin
			len++;
			@(negedge fclk);
		end
		if (!int_n)
			timed_out("int_n to rise");
		check_value(len, expected, what);
	endtask

	task automatic int_length(input logic [15:0] expected);
		wait_int_fall();
		count_int_low(expected, "int_n low time in fclk");
	endtask

	task automatic int_acknowledge(input logic [15:0] expected);
		wait_int_fall();
		iorq_n = 1'b0;
		m1_n = 1'b0;
		count_int_low(expected, "int_n low time with acknowledge");
		bus_idle();
	endtask

	//////////////////////
	// record player
	//////////////////////
	initial
	begin
		int i;
		logic done;
		logic [51:0] rec;
		done = 1'b0;
		bus_idle();
		rst_n = 1'b0;
		$readmemh("test/zx_core_input.txt", records);
		@(negedge fclk);
		@(negedge fclk);
		rst_n = 1'b1;
		if (records[0][51:48] === 4'bxxxx)
		begin
			$display("could not read records from test/zx_core_input.txt");
			fail_run();
		end
		i = 0;
		while (!done && i < rec_max)
		begin
			rec = records[i];
			case (rec[51:48])
				4'h1: io_write(rec[47:32], rec[31:24]);
				4'h2: m1_fetch(rec[47:32]);
				4'h3: mem_read(rec[47:32], rec[23:8], rec[4], rec[0]);
				4'h4: idle_check(rec[47:32], rec[23:8], rec[4], rec[0]);
				4'h5: measure_clkz(rec[23:8]);
				4'h6: reset_first_int(rec[23:8], rec[4]);
				4'h7: int_length(rec[23:8]);
				4'h8: int_acknowledge(rec[23:8]);
				4'hF: done = 1'b1;
				default:
				begin
					$display("unknown operation %0h in record %0d", rec[51:48], i);
					fail_run();
				end
			endcase
			i++;
		end
		if (!done)
		begin
			$display("the data file has no end record");
			fail_run();
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* build.f */
rtl/zx_pkg.sv
rtl/z_clock.sv
rtl/z_ports.sv
rtl/atm_pager.sv
rtl/z_dos.sv
rtl/z_mem_map.sv
rtl/z_int.sv
rtl/zx_core_top.sv
test/tb_zx_core.sv

/* Bender.yml */
package:
  name: zx_core

sources:
  - rtl/zx_pkg.sv
  - rtl/z_clock.sv
  - rtl/z_ports.sv
  - rtl/atm_pager.sv
  - rtl/z_dos.sv
  - rtl/z_mem_map.sv
  - rtl/z_int.sv
  - rtl/zx_core_top.sv
  - target: test
    files:
      - test/tb_zx_core.sv

/* test/zx_core_input.txt */
// columns op_addr_data_expect_romnram_csrom in hex, expect is a page or an fclk count
// op 1 io write, 2 m1 fetch, 3 memory read, 4 idle check, 5 clkz period, 6 reset then first int, 7 int length, 8 int ack, f end
6_0000_00_0401_1_0
7_0000_00_0020_0_0
8_0000_00_0001_0_0
3_0000_00_0002_1_1
4_0000_00_0002_1_0
3_4000_00_0005_0_0
3_8000_00_0002_0_0
3_c000_00_0000_0_0
5_0000_00_0004_0_0
1_7ffd_16_0000_0_0
3_0000_00_0003_1_1
3_c000_00_0006_0_0
2_3d00_00_0000_0_0
3_0000_00_0001_1_1
2_8000_00_0000_0_0
3_0000_00_0003_1_1
1_eff7_04_0000_0_0
3_8000_00_0003_1_1
1_80f7_25_0000_0_0
1_88f7_9a_0000_0_0
3_8000_00_0025_0_0
2_3d00_00_0000_0_0
3_8000_00_001a_1_1
3_0000_00_0003_1_1
1_48f7_11_0000_0_0
3_4000_00_0011_0_0
2_4000_00_0000_0_0
3_8000_00_0025_0_0
3_4000_00_0003_1_1
1_eff7_14_0000_0_0
5_0000_00_0008_0_0
3_8000_00_0025_0_0
f_0000_00_0000_0_0
